// File: rtl/pipe_core_pkg.sv
// shared widths, opcodes, instruction fields and stage records for the integer pipeline.
package pipe_core_pkg;

    localparam int DATA_W = 32;
    localparam int MEM_AW = 6;
    localparam int IMM_W  = 13;

    typedef logic [DATA_W-1:0] data_t;
    typedef logic [4:0]        reg_addr_t;
    typedef logic [MEM_AW-1:0] mem_addr_t;
    typedef logic [3:0]        op_t;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // opcodes.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam op_t OP_NOP  = 4'd0;
    localparam op_t OP_ADD  = 4'd1;
    localparam op_t OP_SUB  = 4'd2;
    localparam op_t OP_AND  = 4'd3;
    localparam op_t OP_OR   = 4'd4;
    localparam op_t OP_XOR  = 4'd5;
    localparam op_t OP_SLT  = 4'd6;
    localparam op_t OP_ADDI = 4'd7;
    localparam op_t OP_MUL  = 4'd8;
    localparam op_t OP_LW   = 4'd9;
    localparam op_t OP_SW   = 4'd10;

    // instruction field positions.
    localparam int OPC_HI = 31;
    localparam int OPC_LO = 28;
    localparam int RD_HI  = 27;
    localparam int RD_LO  = 23;
    localparam int RS1_HI = 22;
    localparam int RS1_LO = 18;
    localparam int RS2_HI = 17;
    localparam int RS2_LO = 13;
    localparam int IMM_HI = 12;
    localparam int IMM_LO = 0;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // stage records.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef struct packed {
        logic      valid;
        op_t       op;
        reg_addr_t rd;
        logic      wr_en;
        data_t     a;
        data_t     b;
        data_t     store_data;
    } issue_t;

    typedef struct packed {
        logic      valid;
        logic      wr_en;
        logic      is_load;
        reg_addr_t rd;
        data_t     data;
        mem_addr_t addr;
        data_t     store_data;
    } pipe_t;

    typedef struct packed {
        logic      wr_en;
        reg_addr_t addr;
        data_t     data;
        logic      ready;
    } fwd_tap_t;

    // tap order is newest first: E, M1..M5, T, C, W.
    localparam int NUM_EXE_TAPS = 7;
    localparam int NUM_RES_TAPS = 2;
    localparam int NUM_TAPS     = NUM_EXE_TAPS + NUM_RES_TAPS;

    typedef fwd_tap_t [NUM_TAPS-1:0] tap_array_t;

    function automatic fwd_tap_t to_tap(input pipe_t stage, input logic rdy);
        fwd_tap_t tap;
        tap.wr_en = stage.valid & stage.wr_en;
        tap.addr  = stage.rd;
        tap.data  = stage.data;
        tap.ready = rdy;
        return tap;
    endfunction

endpackage

// File: rtl/bypass_ctrl.sv
// operand bypass controller: newest-match forwarding and decode stall rules.
module bypass_ctrl (
    input  logic                     clk_i,
    input  logic                     rst_n_i,
    input  pipe_core_pkg::reg_addr_t dec_rs1_i,
    input  pipe_core_pkg::reg_addr_t dec_rs2_i,
    input  pipe_core_pkg::reg_addr_t dec_rd_i,
    input  logic                     dec_wr_en_i,
    input  logic                     dec_is_mul_i,
    input  pipe_core_pkg::tap_array_t taps_i,
    output logic                     bypass_a_en_o,
    output logic                     bypass_b_en_o,
    output pipe_core_pkg::data_t     bypass_data_a_o,
    output pipe_core_pkg::data_t     bypass_data_b_o,
    output logic                     stall_core_o
);
    import pipe_core_pkg::*;

    localparam int TAP_M1 = 1;
    localparam int TAP_M2 = 2;
    localparam int TAP_M4 = 4;

    typedef struct packed {
        logic  hit;
        logic  stall;
        data_t data;
    } fwd_sel_t;

    logic     active_q;
    fwd_sel_t sel_a;
    fwd_sel_t sel_b;
    logic     stall_waw;
    logic     stall_port;

    // first match from the newest end decides.
    function automatic fwd_sel_t search(input reg_addr_t rs, input tap_array_t taps);
        fwd_sel_t sel;
        logic     found;
        sel   = '0;
        found = 1'b0;
        for (int i = 0; i < NUM_TAPS; i++) begin
            if (!found && rs != '0 && taps[i].wr_en && taps[i].addr == rs) begin
                found     = 1'b1;
                sel.hit   = taps[i].ready;
                sel.stall = !taps[i].ready;
                sel.data  = taps[i].data;
            end
        end
        return sel;
    endfunction

    // outputs stay quiet until the cycle after reset is released.
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            active_q <= 1'b0;
        end else begin
            active_q <= 1'b1;
        end
    end

    always_comb begin
        sel_a = search(dec_rs1_i, taps_i);
        sel_b = search(dec_rs2_i, taps_i);
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // structural stalls.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        stall_waw = 1'b0;
        for (int i = TAP_M1; i <= TAP_M4; i++) begin
            if (dec_wr_en_i && taps_i[i].wr_en && taps_i[i].addr == dec_rd_i) begin
                stall_waw = 1'b1;
            end
        end
        // a writer issued now lands in W together with the multiply in M2.
        stall_port = dec_wr_en_i && !dec_is_mul_i && taps_i[TAP_M2].wr_en;
    end

    assign bypass_a_en_o   = active_q & sel_a.hit;
    assign bypass_b_en_o   = active_q & sel_b.hit;
    assign bypass_data_a_o = active_q ? sel_a.data : '0;
    assign bypass_data_b_o = active_q ? sel_b.data : '0;
    assign stall_core_o    = active_q & (sel_a.stall | sel_b.stall | stall_waw | stall_port);

endmodule

// File: rtl/decode_stage.sv
// decode stage: instruction register, field split, operand select and issue.
module decode_stage (
    input  logic                     clk_i,
    input  logic                     rst_n_i,
    input  logic                     instr_valid_i,
    input  pipe_core_pkg::data_t     instr_i,
    input  logic                     stall_i,
    output pipe_core_pkg::reg_addr_t rf_rs1_o,
    output pipe_core_pkg::reg_addr_t rf_rs2_o,
    input  pipe_core_pkg::data_t     rf_data_a_i,
    input  pipe_core_pkg::data_t     rf_data_b_i,
    input  logic                     bypass_a_en_i,
    input  logic                     bypass_b_en_i,
    input  pipe_core_pkg::data_t     bypass_data_a_i,
    input  pipe_core_pkg::data_t     bypass_data_b_i,
    output pipe_core_pkg::reg_addr_t dec_rd_o,
    output logic                     dec_wr_en_o,
    output logic                     dec_is_mul_o,
    output pipe_core_pkg::issue_t    issue_o
);
    import pipe_core_pkg::*;

    logic             dec_valid_q;
    data_t            dec_instr_q;
    op_t              op;
    reg_addr_t        rs1;
    reg_addr_t        rs2;
    logic [IMM_W-1:0] imm;
    data_t            imm_ext;
    logic             uses_rs1;
    logic             uses_rs2;
    logic             uses_imm;
    logic             writes_rd;
    logic             is_store;
    data_t            opnd_a;
    data_t            reg_b;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            dec_valid_q <= 1'b0;
        end else if (!stall_i) begin
            dec_valid_q <= instr_valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!stall_i && instr_valid_i) begin
            dec_instr_q <= instr_i;
        end
    end

    assign op       = dec_instr_q[OPC_HI:OPC_LO];
    assign dec_rd_o = dec_instr_q[RD_HI:RD_LO];
    assign rs1      = dec_instr_q[RS1_HI:RS1_LO];
    assign rs2      = dec_instr_q[RS2_HI:RS2_LO];
    assign imm      = dec_instr_q[IMM_HI:IMM_LO];
    assign imm_ext  = {{(DATA_W-IMM_W){imm[IMM_W-1]}}, imm};

    always_comb begin
        uses_rs1  = 1'b1;
        uses_rs2  = 1'b0;
        uses_imm  = 1'b0;
        writes_rd = 1'b0;
        is_store  = 1'b0;
        case (op)
            OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SLT, OP_MUL: begin
                uses_rs2  = 1'b1;
                writes_rd = 1'b1;
            end
            OP_ADDI, OP_LW: begin
                uses_imm  = 1'b1;
                writes_rd = 1'b1;
            end
            OP_SW: begin
                uses_rs2 = 1'b1;
                uses_imm = 1'b1;
                is_store = 1'b1;
            end
            OP_NOP:  uses_rs1 = 1'b0;
            // reserved codes act as nop.
            default: uses_rs1 = 1'b0;
        endcase
    end

    // unused sources read r0 so they never match a tap.
    assign rf_rs1_o     = (dec_valid_q && uses_rs1) ? rs1 : '0;
    assign rf_rs2_o     = (dec_valid_q && uses_rs2) ? rs2 : '0;
    assign dec_wr_en_o  = dec_valid_q && writes_rd && (dec_rd_o != '0);
    assign dec_is_mul_o = dec_valid_q && (op == OP_MUL);

    assign opnd_a = bypass_a_en_i ? bypass_data_a_i : rf_data_a_i;
    assign reg_b  = bypass_b_en_i ? bypass_data_b_i : rf_data_b_i;

    // only writers and stores go down the pipe, everything else is a bubble.
    always_comb begin
        issue_o.valid      = !stall_i && (dec_wr_en_o || (dec_valid_q && is_store));
        issue_o.op         = op;
        issue_o.rd         = dec_rd_o;
        issue_o.wr_en      = dec_wr_en_o;
        issue_o.a          = opnd_a;
        issue_o.b          = uses_imm ? imm_ext : reg_b;
        issue_o.store_data = reg_b;
    end

endmodule

// File: rtl/execute_stage.sv
// execute paths: ALU E stage, T address stage and five-stage multiplier.
module execute_stage (
    input  logic                   clk_i,
    input  logic                   rst_n_i,
    input  pipe_core_pkg::issue_t  issue_i,
    output pipe_core_pkg::pipe_t   t_o,
    output pipe_core_pkg::pipe_t   m5_o,
    output pipe_core_pkg::fwd_tap_t [pipe_core_pkg::NUM_EXE_TAPS-1:0] taps_o
);
    import pipe_core_pkg::*;

    pipe_t       e_q;
    pipe_t       t_q;
    pipe_t [4:0] m_q;
    pipe_t       e_d;
    pipe_t       t_d;
    pipe_t       m1_d;
    data_t       alu_res;
    logic        is_mul;

    assign is_mul = (issue_i.op == OP_MUL);

    always_comb begin
        case (issue_i.op)
            OP_SUB:  alu_res = issue_i.a - issue_i.b;
            OP_AND:  alu_res = issue_i.a & issue_i.b;
            OP_OR:   alu_res = issue_i.a | issue_i.b;
            OP_XOR:  alu_res = issue_i.a ^ issue_i.b;
            OP_SLT:  alu_res = ($signed(issue_i.a) < $signed(issue_i.b)) ? data_t'(1) : '0;
            // add, addi and the load/store base sum.
            default: alu_res = issue_i.a + issue_i.b;
        endcase
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // next stage contents.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        e_d.valid      = issue_i.valid && !is_mul;
        e_d.wr_en      = issue_i.wr_en;
        e_d.is_load    = (issue_i.op == OP_LW);
        e_d.rd         = issue_i.rd;
        e_d.data       = alu_res;
        e_d.addr       = '0;
        e_d.store_data = issue_i.store_data;

        t_d      = e_q;
        t_d.addr = e_q.data[MEM_AW-1:0];

        // low word of the product only.
        m1_d.valid      = issue_i.valid && is_mul;
        m1_d.wr_en      = issue_i.wr_en;
        m1_d.is_load    = 1'b0;
        m1_d.rd         = issue_i.rd;
        m1_d.data       = issue_i.a * issue_i.b;
        m1_d.addr       = '0;
        m1_d.store_data = '0;
    end

    always_ff @(posedge clk_i) begin
        e_q <= e_d;
        t_q <= t_d;
        m_q <= {m_q[3:0], m1_d};
        if (!rst_n_i) begin
            e_q.valid <= 1'b0;
            t_q.valid <= 1'b0;
            for (int i = 0; i < 5; i++) begin
                m_q[i].valid <= 1'b0;
            end
        end
    end

    assign t_o  = t_q;
    assign m5_o = m_q[4];

    // loads have no data before C, multiplies none before M5.
    always_comb begin
        taps_o[0] = to_tap(e_q, !e_q.is_load);
        for (int i = 1; i <= 4; i++) begin
            taps_o[i] = to_tap(m_q[i-1], 1'b0);
        end
        taps_o[5] = to_tap(m_q[4], 1'b1);
        taps_o[6] = to_tap(t_q, !t_q.is_load);
    end

endmodule

// File: rtl/result_stage.sv
// result side: C scratchpad access, W merge and writeback outputs.
module result_stage #(
    parameter int DMEM_WORDS = 64
) (
    input  logic                      clk_i,
    input  logic                      rst_n_i,
    input  pipe_core_pkg::pipe_t      t_i,
    input  pipe_core_pkg::pipe_t      m5_i,
    output pipe_core_pkg::fwd_tap_t [pipe_core_pkg::NUM_RES_TAPS-1:0] taps_o,
    output logic                      wb_valid_o,
    output pipe_core_pkg::reg_addr_t  wb_addr_o,
    output pipe_core_pkg::data_t      wb_data_o
);
    import pipe_core_pkg::*;

    pipe_t c_q;
    pipe_t w_q;
    pipe_t c_view;
    pipe_t w_d;
    data_t dmem [DMEM_WORDS];
    logic  c_store;

    // a valid non-writer in C can only be a store.
    assign c_store = c_q.valid && !c_q.wr_en;

    always_ff @(posedge clk_i) begin
        if (c_store) begin
            dmem[c_q.addr] <= c_q.store_data;
        end
    end

    always_comb begin
        c_view = c_q;
        if (c_q.is_load) begin
            c_view.data = dmem[c_q.addr];
        end

        // M5 and a C writer never meet here.
        if (m5_i.valid && m5_i.wr_en) begin
            w_d = m5_i;
        end else begin
            w_d       = c_view;
            w_d.valid = c_q.valid && c_q.wr_en;
        end
    end

    always_ff @(posedge clk_i) begin
        c_q <= t_i;
        w_q <= w_d;
        if (!rst_n_i) begin
            c_q.valid <= 1'b0;
            w_q.valid <= 1'b0;
        end
    end

    assign taps_o[0] = to_tap(c_view, 1'b1);
    assign taps_o[1] = to_tap(w_q, 1'b1);

    assign wb_valid_o = w_q.valid && w_q.wr_en;
    assign wb_addr_o  = w_q.rd;
    assign wb_data_o  = w_q.data;

endmodule

// File: rtl/reg_file.sv
// 32 x 32 register file, two async read ports, one write port, r0 fixed at zero.
module reg_file (
    input  logic                     clk_i,
    input  pipe_core_pkg::reg_addr_t rs1_i,
    input  pipe_core_pkg::reg_addr_t rs2_i,
    output pipe_core_pkg::data_t     data_a_o,
    output pipe_core_pkg::data_t     data_b_o,
    input  logic                     wr_en_i,
    input  pipe_core_pkg::reg_addr_t wr_addr_i,
    input  pipe_core_pkg::data_t     wr_data_i
);
    import pipe_core_pkg::*;

    data_t regs [32];

    always_ff @(posedge clk_i) begin
        if (wr_en_i && wr_addr_i != '0) begin
            regs[wr_addr_i] <= wr_data_i;
        end
    end

    // same-cycle write data comes through the W tap instead.
    assign data_a_o = (rs1_i == '0) ? '0 : regs[rs1_i];
    assign data_b_o = (rs2_i == '0) ? '0 : regs[rs2_i];

endmodule

// File: rtl/pipe_core_top.sv
// in-order integer pipeline top: decode, bypass, execute paths and writeback.
module pipe_core_top #(
    parameter int DMEM_WORDS = 64
) (
    input  logic                     clk_i,
    input  logic                     rst_n_i,
    input  logic                     instr_valid_i,
    input  pipe_core_pkg::data_t     instr_i,
    output logic                     stall_o,
    output logic                     wb_valid_o,
    output pipe_core_pkg::reg_addr_t wb_addr_o,
    output pipe_core_pkg::data_t     wb_data_o
);
    import pipe_core_pkg::*;

    reg_addr_t  rf_rs1;
    reg_addr_t  rf_rs2;
    data_t      rf_data_a;
    data_t      rf_data_b;
    logic       byp_a_en;
    logic       byp_b_en;
    data_t      byp_data_a;
    data_t      byp_data_b;
    reg_addr_t  dec_rd;
    logic       dec_wr_en;
    logic       dec_is_mul;
    issue_t     issue;
    pipe_t      t_stage;
    pipe_t      m5_stage;
    tap_array_t taps;

    fwd_tap_t [NUM_EXE_TAPS-1:0] exe_taps;
    fwd_tap_t [NUM_RES_TAPS-1:0] res_taps;

    // execute taps sit at the newest end.
    assign taps = {res_taps, exe_taps};

    decode_stage u_decode (
        .clk_i           (clk_i),
        .rst_n_i         (rst_n_i),
        .instr_valid_i   (instr_valid_i),
        .instr_i         (instr_i),
        .stall_i         (stall_o),
        .rf_rs1_o        (rf_rs1),
        .rf_rs2_o        (rf_rs2),
        .rf_data_a_i     (rf_data_a),
        .rf_data_b_i     (rf_data_b),
        .bypass_a_en_i   (byp_a_en),
        .bypass_b_en_i   (byp_b_en),
        .bypass_data_a_i (byp_data_a),
        .bypass_data_b_i (byp_data_b),
        .dec_rd_o        (dec_rd),
        .dec_wr_en_o     (dec_wr_en),
        .dec_is_mul_o    (dec_is_mul),
        .issue_o         (issue)
    );

    bypass_ctrl u_bypass (
        .clk_i           (clk_i),
        .rst_n_i         (rst_n_i),
        .dec_rs1_i       (rf_rs1),
        .dec_rs2_i       (rf_rs2),
        .dec_rd_i        (dec_rd),
        .dec_wr_en_i     (dec_wr_en),
        .dec_is_mul_i    (dec_is_mul),
        .taps_i          (taps),
        .bypass_a_en_o   (byp_a_en),
        .bypass_b_en_o   (byp_b_en),
        .bypass_data_a_o (byp_data_a),
        .bypass_data_b_o (byp_data_b),
        .stall_core_o    (stall_o)
    );

    execute_stage u_execute (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .issue_i (issue),
        .t_o     (t_stage),
        .m5_o    (m5_stage),
        .taps_o  (exe_taps)
    );

    result_stage #(
        .DMEM_WORDS (DMEM_WORDS)
    ) u_result (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .t_i        (t_stage),
        .m5_i       (m5_stage),
        .taps_o     (res_taps),
        .wb_valid_o (wb_valid_o),
        .wb_addr_o  (wb_addr_o),
        .wb_data_o  (wb_data_o)
    );

    reg_file u_regs (
        .clk_i     (clk_i),
        .rs1_i     (rf_rs1),
        .rs2_i     (rf_rs2),
        .data_a_o  (rf_data_a),
        .data_b_o  (rf_data_b),
        .wr_en_i   (wb_valid_o),
        .wr_addr_i (wb_addr_o),
        .wr_data_i (wb_data_o)
    );

endmodule

// File: tb/pipe_core_chk.sv
// port-level assertions for the pipeline top, attached by bind.
module pipe_core_chk (
    input logic                     clk_i,
    input logic                     rst_n_i,
    input logic                     stall_i,
    input logic                     wb_valid_i,
    input pipe_core_pkg::reg_addr_t wb_addr_i,
    input pipe_core_pkg::data_t     wb_data_i
);
    timeunit 1ns;
    timeprecision 1ps;

    // register 0 is never written.
    no_wb_to_r0: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        wb_valid_i |-> (wb_addr_i != '0))
        else $error("writeback to register 0");

    // outputs quiet once reset has been seen for a full cycle.
    quiet_in_reset: assert property (@(posedge clk_i)
        (!rst_n_i && $past(!rst_n_i)) |-> (!stall_i && !wb_valid_i))
        else $error("stall or writeback active during reset");

    // each write is shown for one cycle only.
    single_cycle_wb: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (wb_valid_i && $past(wb_valid_i)) |->
            ((wb_addr_i != $past(wb_addr_i)) || (wb_data_i != $past(wb_data_i))))
        else $error("writeback held for a second cycle");

endmodule

bind pipe_core_top pipe_core_chk u_chk (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .stall_i    (stall_o),
    .wb_valid_i (wb_valid_o),
    .wb_addr_i  (wb_addr_o),
    .wb_data_i  (wb_data_o)
);

// File: tb/pipe_core_tb.sv
// in-order pipeline testbench running directed and random programs against a reference model.
module pipe_core_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import pipe_core_pkg::*;

    localparam int CLK_PERIOD   = 40;
    localparam int RESET_CYCLES = 16;
    localparam int DRIVE_DELAY  = 2;
    localparam int NUM_RANDOM   = 200;
    // register setup, ALU chains, multiplies, memory, port collisions, random.
    localparam int NUM_INSTR    = 31 + 26 + 7 + 15 + 15 + NUM_RANDOM;
    localparam int CYCLE_LIMIT  = NUM_INSTR * 12 + 200;

    logic      clk_i;
    logic      rst_n_i;
    logic      instr_valid_i;
    data_t     instr_i;
    logic      stall_o;
    logic      wb_valid_o;
    reg_addr_t wb_addr_o;
    data_t     wb_data_o;

    data_t  model_regs [32];
    data_t  model_mem [64];
    logic   mem_written [64];
    data_t  exp_q [32][$];
    int     cycles = 0;
    int     error_count;
    integer seed;

    pipe_core_top #(
        .DMEM_WORDS (64)
    ) uut (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .instr_valid_i (instr_valid_i),
        .instr_i       (instr_i),
        .stall_o       (stall_o),
        .wb_valid_o    (wb_valid_o),
        .wb_addr_o     (wb_addr_o),
        .wb_data_o     (wb_data_o)
    );

    always #(CLK_PERIOD / 2) clk_i = ~clk_i;

    always @(posedge clk_i) begin
        cycles = cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("*** TEST FAILED ***");
            $fatal(1, "timeout");
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // reference model and result checking.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    function automatic data_t encode(input op_t op, input int rd, input int rs1,
                                     input int rs2, input int imm);
        return {op, reg_addr_t'(rd), reg_addr_t'(rs1), reg_addr_t'(rs2), IMM_W'(imm)};
    endfunction

    task automatic check(input string what, input data_t got, input data_t expected);
        if (got !== expected) begin
            error_count++;
            $display("error at %0d ns: %s: got %08h, expected %08h",
                     $time, what, got, expected);
            $display("*** TEST FAILED ***");
            $fatal(1, "stopping at the first mismatch");
        end
    endtask

    // executes in program order and queues one expected value per register write.
    task automatic model_exec(input data_t instr);
        op_t       op;
        reg_addr_t rd;
        data_t     a;
        data_t     b;
        data_t     imm;
        data_t     res;
        mem_addr_t addr;
        logic      writes;
        op     = instr[OPC_HI:OPC_LO];
        rd     = instr[RD_HI:RD_LO];
        a      = model_regs[instr[RS1_HI:RS1_LO]];
        b      = model_regs[instr[RS2_HI:RS2_LO]];
        imm    = {{(DATA_W-IMM_W){instr[IMM_HI]}}, instr[IMM_HI:IMM_LO]};
        addr   = mem_addr_t'(a + imm);
        res    = '0;
        writes = 1'b1;
        case (op)
            OP_ADD:  res = a + b;
            OP_SUB:  res = a - b;
            OP_AND:  res = a & b;
            OP_OR:   res = a | b;
            OP_XOR:  res = a ^ b;
            OP_SLT:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            OP_ADDI: res = a + imm;
            OP_MUL:  res = a * b;
            OP_LW:   res = model_mem[addr];
            OP_SW: begin
                model_mem[addr]   = b;
                mem_written[addr] = 1'b1;
                writes            = 1'b0;
            end
            default: writes = 1'b0;
        endcase
        if (writes && rd != '0) begin
            model_regs[rd] = res;
            exp_q[rd].push_back(res);
        end
    endtask

    always @(negedge clk_i) begin
        data_t exp_val;
        if (rst_n_i && wb_valid_o) begin
            if (exp_q[wb_addr_o].size() == 0) begin
                $display("unexpected writeback to r%0d at %0d ns", wb_addr_o, $time);
                $display("*** TEST FAILED ***");
                $fatal(1, "writeback with no pending write");
            end else begin
                exp_val = exp_q[wb_addr_o].pop_front();
                check($sformatf("r%0d writeback", wb_addr_o), wb_data_o, exp_val);
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // stimulus.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // hold the word until a rising edge sees stall low.
    task automatic issue_instr(input data_t instr);
        instr_valid_i = 1'b1;
        instr_i       = instr;
        @(negedge clk_i);
        while (stall_o) begin
            @(negedge clk_i);
        end
        @(posedge clk_i);
        #DRIVE_DELAY;
        instr_valid_i = 1'b0;
        model_exec(instr);
    endtask

    task automatic idle(input int n);
        repeat (n) @(posedge clk_i);
        #DRIVE_DELAY;
    endtask

    task automatic quiet_after_reset();
        repeat (4) begin
            @(negedge clk_i);
            check("stall_o after reset", data_t'(stall_o), 32'd0);
            check("wb_valid_o after reset", data_t'(wb_valid_o), 32'd0);
        end
        idle(1);
    endtask

    task automatic load_registers();
        for (int r = 1; r < 32; r++) begin
            issue_instr(encode(OP_ADDI, r, 0, 0, r * 97 - 1500));
        end
    endtask

    // consumer sits 1 to 4 slots behind its producer.
    task automatic alu_chains();
        for (int gap = 1; gap <= 4; gap++) begin
            issue_instr(encode(OP_ADD, 5, 9, gap + 1, 0));
            for (int k = 0; k < gap - 1; k++) begin
                issue_instr(encode(OP_XOR, 20 + k, 3, 4, 0));
            end
            issue_instr(encode(OP_SUB, 6, 5, 10 + gap, 0));
            issue_instr(encode(OP_SLT, 7, 6, 5, 0));
            issue_instr(encode(OP_OR, 8, 7, 6, 0));
            issue_instr(encode(OP_ADDI, 9, 8, 0, -5 * gap));
        end
    endtask

    task automatic multiply_hazards();
        issue_instr(encode(OP_MUL, 10, 1, 2, 0));
        issue_instr(encode(OP_ADD, 11, 10, 3, 0));
        issue_instr(encode(OP_MUL, 12, 11, 10, 0));
        // WAW against the multiply still in flight.
        issue_instr(encode(OP_ADDI, 12, 4, 0, 9));
        issue_instr(encode(OP_SUB, 13, 12, 11, 0));
        issue_instr(encode(OP_MUL, 10, 13, 13, 0));
        issue_instr(encode(OP_XOR, 14, 10, 1, 0));
    endtask

    task automatic store_load();
        issue_instr(encode(OP_SW, 0, 0, 1, 4));
        issue_instr(encode(OP_SW, 0, 0, 2, 5));
        issue_instr(encode(OP_SW, 0, 0, 10, 6));
        issue_instr(encode(OP_SW, 0, 0, 12, 7));
        issue_instr(encode(OP_LW, 17, 0, 0, 4));
        issue_instr(encode(OP_ADD, 18, 17, 17, 0));
        issue_instr(encode(OP_LW, 19, 0, 0, 5));
        issue_instr(encode(OP_SUB, 20, 19, 17, 0));
        issue_instr(encode(OP_LW, 21, 0, 0, 6));
        issue_instr(encode(OP_LW, 22, 0, 0, 7));
        issue_instr(encode(OP_OR, 23, 22, 21, 0));
        issue_instr(encode(OP_ADDI, 24, 0, 0, 40));
        issue_instr(encode(OP_SW, 0, 24, 18, -2));
        issue_instr(encode(OP_LW, 25, 24, 0, -2));
        issue_instr(encode(OP_ADD, 26, 25, 1, 0));
    endtask

    // the XOR reaches decode while the multiply sits in M2.
    task automatic port_collisions();
        for (int r = 0; r < 3; r++) begin
            issue_instr(encode(OP_MUL, 27, 1 + r, 2 + r, 0));
            issue_instr(encode(OP_ADD, 28, 3 + r, 4 + r, 0));
            issue_instr(encode(OP_XOR, 29, 5 + r, 6 + r, 0));
            issue_instr(encode(OP_OR, 30, 28, 29, 0));
            issue_instr(encode(OP_MUL, 31, 27, 30, 0));
        end
    endtask

    task automatic random_program();
        data_t     rnd;
        op_t       op;
        int        rd;
        int        rs1;
        int        rs2;
        int        imm;
        int        prev_rd;
        mem_addr_t addr;
        prev_rd = 0;
        for (int n = 0; n < NUM_RANDOM; n++) begin
            rnd  = $random(seed);
            op   = op_t'(rnd[3:0] % 4'd10 + 4'd1);
            rd   = int'(rnd[7:4]);
            rs1  = int'(rnd[11:8]);
            rs2  = int'(rnd[15:12]);
            imm  = int'(rnd[28:16]);
            addr = mem_addr_t'(model_regs[rs1] + data_t'(imm));
            // loads only see words written earlier.
            if (op == OP_LW && !mem_written[addr]) begin
                op = OP_SW;
            end
            // back-to-back writes to one register would look like a held write.
            if (op != OP_SW && rd != 0 && rd == prev_rd) begin
                rd = (rd + 1) % 16;
            end
            prev_rd = (op == OP_SW) ? 0 : rd;
            if (rnd[31:29] == 3'b000) begin
                idle(1);
            end
            issue_instr(encode(op, rd, rs1, rs2, imm));
        end
    endtask

    task automatic wait_drain();
        int pending;
        pending = 1;
        while (pending != 0) begin
            @(posedge clk_i);
            pending = 0;
            for (int r = 0; r < 32; r++) begin
                pending += exp_q[r].size();
            end
        end
    endtask

    initial begin
        seed          = 34;
        error_count   = 0;
        clk_i         = 1'b0;
        rst_n_i       = 1'b0;
        instr_valid_i = 1'b0;
        instr_i       = '0;
        for (int r = 0; r < 32; r++) begin
            model_regs[r] = '0;
        end
        for (int a = 0; a < 64; a++) begin
            model_mem[a]   = '0;
            mem_written[a] = 1'b0;
        end
        repeat (RESET_CYCLES) @(posedge clk_i);
        #DRIVE_DELAY;
        rst_n_i = 1'b1;

        quiet_after_reset();
        load_registers();
        alu_chains();
        multiply_hazards();
        store_load();
        port_collisions();
        random_program();
        wait_drain();
        // stray writebacks would still show up here.
        idle(4);

        if (error_count == 0) begin
            $display("*** TEST PASSED ***");
            $finish;
        end else begin
            $display("*** TEST FAILED ***");
            $fatal(1, "mismatches were found");
        end
    end

endmodule

// File: pipe_core_top.f
rtl/pipe_core_pkg.sv
rtl/bypass_ctrl.sv
rtl/decode_stage.sv
rtl/execute_stage.sv
rtl/result_stage.sv
rtl/reg_file.sv
rtl/pipe_core_top.sv
tb/pipe_core_chk.sv
tb/pipe_core_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= pipe_core_tb
FLIST     ?= pipe_core_top.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --assert -j 0
PASS_MSG  ?= *** TEST PASSED ***

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_MSG)'

clean:
	rm -rf $(BUILD_DIR)
